/* test/ifu_assert.sv */
`timescale 1ns/1ps

module ifu_assert
  import ifu_cfg_pkg::*;
  import rv_isa_pkg::*;
(
  input logic              clk,
  input logic              rst,
  input logic [ADDR_W-1:0] araddr_i,
  input logic              arvalid_i,
  input logic              rvalid_i,
  input logic [INST_W-1:0] inst_i,
  input logic [ADDR_W-1:0] pc_i,
  input logic              valid_i,
  input logic              ready_i,
  input logic              spec_i,
  input logic              good_i,
  input logic              bad_i
);

  // ----------------------------------------
  // memory port
  // ----------------------------------------
  addr_hold: assert property (@(posedge clk) disable iff (rst)
    (arvalid_i && !rvalid_i) |=> $stable(araddr_i))
    else $error("mem_araddr_o changed during a pending read");

  // ----------------------------------------
  // decode handshake
  // ----------------------------------------
  out_hold: assert property (@(posedge clk) disable iff (rst)
    (valid_i && !ready_i) |=> ($stable(inst_i) && $stable(pc_i)))
    else $error("inst_o or pc_o changed while stalled by decode");

  no_valid_bad: assert property (@(posedge clk) disable iff (rst)
    bad_i |-> !valid_i)
    else $error("valid_o high during a bad speculation");

  reset_quiet: assert property (@(posedge clk)
    $fell(rst) |-> !(valid_i || arvalid_i || spec_i || good_i || bad_i))
    else $error("control output high right after reset");

endmodule

bind ifu_top ifu_assert u_assert (
  .clk       (clk),
  .rst       (rst),
  .araddr_i  (mem_araddr_o),
  .arvalid_i (mem_arvalid_o),
  .rvalid_i  (mem_rvalid_i),
  .inst_i    (inst_o),
  .pc_i      (pc_o),
  .valid_i   (valid_o),
  .ready_i   (ready_i),
  .spec_i    (spec_o),
  .good_i    (spec_good_o),
  .bad_i     (spec_bad_o)
);

/* test/ifu_tb.sv */
`timescale 1ns/1ps

module ifu_tb
  import ifu_cfg_pkg::*;
  import rv_isa_pkg::*;
();

  logic clk = 1'b0;
  logic rst, mem_arvalid_o, mem_rvalid_i, valid_o, ready_i;
  logic redirect_valid_i, redirect_taken_i, redirect_retire_i;
  logic spec_o, spec_good_o, spec_bad_o;
  logic [ADDR_W-1:0] mem_araddr_o, redirect_pc_i, pc_o;
  logic [INST_W-1:0] mem_rdata_i, inst_o;

  // image and scripted resolution, indexed by pc[9:2]
  logic [INST_W-1:0] img [256];
  logic [ADDR_W-1:0] tgt [256];
  bit                tk  [256];
  logic [ADDR_W-1:0] req_pc_q [$];
  bit                req_tk_q [$];

  logic [ADDR_W-1:0] exp_pc, btb, spec_tgt;
  logic [INST_W-1:0] exp_inst;
  bit   m_stall, m_spec, btb_ok, good_due, busy, timed_out;
  int   xfer_cnt, good_cnt, bad_cnt, spec_cnt, rd_cnt, err_cnt, test_cnt;

  ifu_top dut0 (.*);

  always #10 clk = ~clk;

  function automatic logic [INST_W-1:0] fill_word(input logic [ADDR_W-1:0] a);
    logic [11:0] imm;
    imm = a[31:20] ^ a[19:8] ^ {a[7:0], 4'h0};
    return {imm, 5'd1, 3'b000, 5'd1, 7'b0010011};
  endfunction

  function automatic logic [INST_W-1:0] ref_fetch(input logic [ADDR_W-1:0] pc);
    return img[pc[9:2]];
  endfunction

  function automatic bit is_ctrl(input logic [INST_W-1:0] w);
    return w[6:0] inside {OP_JAL, OP_JALR, OP_BRANCH, OP_SYSTEM};
  endfunction

  task automatic flag_error(input string msg);
    $display("[FAIL] %0t %s", $time, msg);
    err_cnt++;
  endtask

  // ----------------------------------------
  // memory, backend and decode models
  // ----------------------------------------
  initial begin
    forever begin
      @(negedge clk);
      mem_rvalid_i = 1'b0;
      if (!rst && mem_arvalid_o) begin
        repeat ($urandom_range(0, 3)) @(negedge clk);
        mem_rdata_i  = img[mem_araddr_o[9:2]];
        mem_rvalid_i = 1'b1;
        rd_cnt++;
      end
    end
  end

  initial begin
    forever begin
      @(negedge clk);
      redirect_valid_i = 1'b0;
      if (!rst && req_pc_q.size() > 0) begin
        busy = 1'b1;
        redirect_pc_i     = req_pc_q.pop_front();
        redirect_taken_i  = req_tk_q.pop_front();
        redirect_retire_i = !redirect_taken_i;
        repeat ($urandom_range(1, 4)) @(negedge clk);
        redirect_valid_i = 1'b1;
        busy = 1'b0;
      end
    end
  end

  always @(negedge clk) ready_i = ($urandom % 4) != 0;

  // ----------------------------------------
  // compare process
  // ----------------------------------------
  always @(posedge clk) begin
    if (rst) begin
      exp_pc = PC_INIT;
      {m_stall, m_spec, btb_ok, good_due} = '0;
      {xfer_cnt, good_cnt, bad_cnt, spec_cnt} = '0;
      req_pc_q.delete();
      req_tk_q.delete();
    end else begin
      if (good_due && !spec_good_o) flag_error("spec_good_o missing after a match");
      good_due = 1'b0;
      if (m_spec && !spec_o) flag_error("spec_o low on a speculative path");
      if (spec_o) spec_cnt++;
      if (spec_good_o) good_cnt++;
      if (valid_o && ready_i) begin
        xfer_cnt++;
        exp_inst = ref_fetch(exp_pc);
        if (m_stall) flag_error($sformatf("transfer at %h during a stall", pc_o));
        if (pc_o !== exp_pc) flag_error($sformatf("pc_o %h, expected %h", pc_o, exp_pc));
        if (inst_o !== exp_inst) begin
          flag_error($sformatf("inst_o %h at %h, expected %h", inst_o, exp_pc, exp_inst));
        end
        if (is_ctrl(exp_inst) || exp_inst[6:0] == OP_LOAD) begin
          req_pc_q.push_back(tgt[exp_pc[9:2]]);
          req_tk_q.push_back(tk[exp_pc[9:2]]);
          if (is_ctrl(exp_inst) && btb_ok && !m_spec) begin
            m_spec   = 1'b1;
            spec_tgt = btb;
            exp_pc   = btb;
          end else begin
            m_stall = 1'b1;
          end
        end else begin
          exp_pc = exp_pc + 4;
        end
      end
      if (redirect_valid_i && (redirect_taken_i || redirect_retire_i)) begin
        if (m_spec) begin
          if (redirect_pc_i == spec_tgt) begin
            good_due = 1'b1;
          end else begin
            if (!spec_bad_o) flag_error("spec_bad_o low on a mismatch");
            exp_pc = redirect_pc_i;
            bad_cnt++;
          end
          m_spec = 1'b0;
        end else if (m_stall) begin
          m_stall = 1'b0;
          exp_pc  = redirect_pc_i;
        end
        if (redirect_taken_i) begin
          btb_ok = 1'b1;
          btb    = redirect_pc_i;
        end
      end
    end
  end

  // ----------------------------------------
  // test helpers
  // ----------------------------------------
  task automatic wait_xfers(input int n);
    int t;
    t = 0;
    while (xfer_cnt < n && t < 5000) begin
      @(negedge clk);
      t++;
    end
    if (xfer_cnt < n) begin
      $display("timeout: %0d of %0d transfers seen", xfer_cnt, n);
      err_cnt++;
      timed_out = 1'b1;
    end
  endtask

  task automatic start_test();
    int t;
    t = 0;
    while ((req_pc_q.size() > 0 || busy) && t < 5000) begin
      @(negedge clk);
      t++;
    end
    if (req_pc_q.size() > 0 || busy) begin
      $display("timeout: backend never went idle");
      err_cnt++;
      timed_out = 1'b1;
    end
    rst = 1'b1;
    for (int i = 0; i < 256; i++) begin
      img[i] = fill_word(PC_INIT + 4 * i);
      tgt[i] = '0;
      tk[i]  = 1'b0;
    end
    repeat (16) @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic end_test(input string name, input int errs_before);
    test_cnt++;
    $display("test %-12s %0d errors", name, err_cnt - errs_before);
  endtask

  task automatic run_all();
    int e;
    int snap;
    e = err_cnt;
    start_test();
    wait_xfers(20);
    end_test("sequential", e);

    // 8 word loop fills the cache exactly
    e = err_cnt;
    start_test();
    img[7] = {25'd0, OP_BRANCH};
    tgt[7] = PC_INIT;
    tk[7]  = 1'b1;
    wait_xfers(9);
    snap = rd_cnt;
    wait_xfers(24);
    if (rd_cnt != snap) flag_error($sformatf("%0d reads on a cached pass", rd_cnt - snap));
    end_test("reuse", e);

    e = err_cnt;
    start_test();
    img[2] = {17'd0, 3'b010, 5'd0, OP_LOAD};
    tgt[2] = PC_INIT + 12;
    img[5] = {25'd0, OP_BRANCH};
    tgt[5] = PC_INIT + 24;
    wait_xfers(10);
    if (spec_cnt != 0) flag_error("speculation with an empty btb");
    end_test("stall", e);

    e = err_cnt;
    start_test();
    img[9] = {25'd0, OP_BRANCH};
    tgt[9] = PC_INIT;
    tk[9]  = 1'b1;
    wait_xfers(40);
    if (good_cnt < 2) flag_error($sformatf("only %0d good speculations", good_cnt));
    end_test("spec_good", e);

    // btb learns +0x40, second branch resolves to +0xa0
    e = err_cnt;
    start_test();
    img[1]  = {25'd0, OP_JAL};
    tgt[1]  = PC_INIT + 'h40;
    tk[1]   = 1'b1;
    img[24] = {25'd0, OP_BRANCH};
    tgt[24] = PC_INIT + 'ha0;
    tk[24]  = 1'b1;
    wait_xfers(25);
    if (bad_cnt != 1) flag_error($sformatf("%0d bad speculations, expected 1", bad_cnt));
    end_test("spec_bad", e);

    e = err_cnt;
    start_test();
    img[2] = INST_FENCE_I;
    img[4] = {25'd0, OP_BRANCH};
    tgt[4] = PC_INIT;
    tk[4]  = 1'b1;
    wait_xfers(3);
    img[0] = img[0] ^ 32'hfff0_0000;
    img[1] = img[1] ^ 32'hfff0_0000;
    wait_xfers(5);
    snap = rd_cnt;
    wait_xfers(7);
    if (rd_cnt <= snap) flag_error("no refill after fence.i");
    end_test("fence_i", e);
  endtask

  initial begin
    void'($urandom(94753));
    rst = 1'b1;
    ready_i = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rdata_i = '0;
    redirect_valid_i = 1'b0;
    redirect_pc_i = '0;
    redirect_taken_i = 1'b0;
    redirect_retire_i = 1'b0;
    fork
      run_all();
      wait (timed_out);
    join_any
    disable fork;
    $display("%0d tests run, %0d errors", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
verilog/rv_isa_pkg.sv
verilog/ifu_cfg_pkg.sv
verilog/l1i_cache.sv
verilog/ifu_pc_ctrl.sv
verilog/ifu_top.sv
test/ifu_assert.sv
test/ifu_tb.sv

/* verilog/ifu_cfg_pkg.sv */
package ifu_cfg_pkg;

  // ----------------------------------------
  // fetch address
  // ----------------------------------------
  localparam int ADDR_W = 32;

  // first instruction after reset
  localparam logic [ADDR_W-1:0] PC_INIT = 32'h8000_0000;

  // ----------------------------------------
  // l1 icache geometry
  // ----------------------------------------
  // log2 of words per line
  localparam int LINE_LEN = 1;

  // log2 of sets, direct mapped
  localparam int SET_LEN = 2;

  // address = {tag, set, word, byte}
  localparam int TAG_W = ADDR_W - SET_LEN - LINE_LEN - 2;

endpackage

/* verilog/ifu_pc_ctrl.sv */
`timescale 1ns/1ps

module ifu_pc_ctrl
  import ifu_cfg_pkg::*;
  import rv_isa_pkg::*;
(
  input  logic              clk,
  input  logic              rst,

  // cache lookup
  output logic [ADDR_W-1:0] fetch_pc_o,
  output logic              flush_all_o,
  input  logic              hit_i,
  input  logic [INST_W-1:0] hit_inst_i,
  input  logic              refill_idle_i,

  // backend redirect
  input  logic              redirect_valid_i,
  input  logic [ADDR_W-1:0] redirect_pc_i,
  input  logic              redirect_taken_i,
  input  logic              redirect_retire_i,

  // to decode
  output logic [INST_W-1:0] inst_o,
  output logic [ADDR_W-1:0] pc_o,
  output logic              valid_o,
  input  logic              ready_i,

  output logic              spec_o,
  output logic              spec_good_o,
  output logic              spec_bad_o
);

  logic [ADDR_W-1:0] pc_q;
  logic              stall_q;

  // one entry btb, last taken target
  logic [ADDR_W-1:0] btb_q;
  logic              btb_valid_q;

  logic [ADDR_W-1:0] spec_target_q;
  logic [ADDR_W-1:0] fix_pc_q;
  logic              spec_q;
  logic              spec_good_q;
  logic              spec_bad_q;

  // ----------------------------------------
  // predecode
  // ----------------------------------------
  logic [6:0] opcode;
  logic       is_branch;
  logic       is_load;
  logic       is_fence_i;

  assign opcode = hit_inst_i[6:0];

  assign is_branch = (opcode == OP_JAL) || (opcode == OP_JALR) ||
                     (opcode == OP_BRANCH) || (opcode == OP_SYSTEM);
  assign is_load    = (opcode == OP_LOAD);
  assign is_fence_i = (hit_inst_i == INST_FENCE_I);

  // ----------------------------------------
  // handshake and resolution
  // ----------------------------------------
  logic xfer;
  logic resolve;
  logic spec_match;
  logic spec_miss;
  logic flush_go;

  assign resolve    = redirect_valid_i && (redirect_taken_i || redirect_retire_i);
  assign spec_match = resolve && spec_q && !spec_bad_q && (redirect_pc_i == spec_target_q);
  assign spec_miss  = resolve && spec_q && !spec_bad_q && (redirect_pc_i != spec_target_q);

  // wrong path is never handed to decode
  assign spec_bad_o  = spec_bad_q || spec_miss;
  assign spec_o      = spec_q;
  assign spec_good_o = spec_good_q;

  assign valid_o = hit_i && !stall_q && !spec_bad_o;
  assign inst_o  = hit_inst_i;
  assign pc_o    = pc_q;
  assign xfer    = valid_o && ready_i;

  assign fetch_pc_o  = pc_q;
  assign flush_all_o = xfer && is_fence_i;

  // restart waits for the cache and for decode
  assign flush_go = spec_bad_q && refill_idle_i && ready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q        <= PC_INIT;
      stall_q     <= 1'b0;
      btb_valid_q <= 1'b0;
      spec_q      <= 1'b0;
      spec_good_q <= 1'b0;
      spec_bad_q  <= 1'b0;
    end else begin
      spec_good_q <= spec_match;

      if (redirect_valid_i && redirect_taken_i) begin
        btb_valid_q <= 1'b1;
      end

      if (xfer) begin
        if (is_branch) begin
          if (btb_valid_q && !spec_q) begin
            pc_q   <= btb_q;
            spec_q <= 1'b1;
          end else begin
            stall_q <= 1'b1;
          end
        end else if (is_load) begin
          stall_q <= 1'b1;
        end else begin
          pc_q <= pc_q + ADDR_W'(4);
        end
      end

      // plain stall, backend supplies the next pc
      if (stall_q && resolve && !spec_q) begin
        stall_q <= 1'b0;
        pc_q    <= redirect_pc_i;
      end

      if (spec_match) begin
        spec_q <= 1'b0;
      end

      if (spec_miss) begin
        spec_bad_q <= 1'b1;
      end

      if (flush_go) begin
        pc_q       <= fix_pc_q;
        stall_q    <= 1'b0;
        spec_q     <= 1'b0;
        spec_bad_q <= 1'b0;
      end
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (redirect_valid_i && redirect_taken_i) begin
      btb_q <= redirect_pc_i;
    end
    if (xfer && is_branch && btb_valid_q && !spec_q) begin
      spec_target_q <= btb_q;
    end
    if (spec_miss) begin
      fix_pc_q <= redirect_pc_i;
    end
  end

endmodule

/* verilog/ifu_top.sv */
`timescale 1ns/1ps

module ifu_top
  import ifu_cfg_pkg::*;
  import rv_isa_pkg::*;
(
  input  logic              clk,
  input  logic              rst,

  // memory read port
  output logic [ADDR_W-1:0] mem_araddr_o,
  output logic              mem_arvalid_o,
  input  logic [INST_W-1:0] mem_rdata_i,
  input  logic              mem_rvalid_i,

  // backend redirect
  input  logic              redirect_valid_i,
  input  logic [ADDR_W-1:0] redirect_pc_i,
  input  logic              redirect_taken_i,
  input  logic              redirect_retire_i,

  // to decode
  output logic [INST_W-1:0] inst_o,
  output logic [ADDR_W-1:0] pc_o,
  output logic              valid_o,
  input  logic              ready_i,

  output logic              spec_o,
  output logic              spec_good_o,
  output logic              spec_bad_o
);

  logic [ADDR_W-1:0] fetch_pc;
  logic              flush_all;
  logic              hit;
  logic [INST_W-1:0] hit_inst;
  logic              refill_idle;

  ifu_pc_ctrl u_pc_ctrl (
    .clk               (clk),
    .rst               (rst),
    .fetch_pc_o        (fetch_pc),
    .flush_all_o       (flush_all),
    .hit_i             (hit),
    .hit_inst_i        (hit_inst),
    .refill_idle_i     (refill_idle),
    .redirect_valid_i  (redirect_valid_i),
    .redirect_pc_i     (redirect_pc_i),
    .redirect_taken_i  (redirect_taken_i),
    .redirect_retire_i (redirect_retire_i),
    .inst_o            (inst_o),
    .pc_o              (pc_o),
    .valid_o           (valid_o),
    .ready_i           (ready_i),
    .spec_o            (spec_o),
    .spec_good_o       (spec_good_o),
    .spec_bad_o        (spec_bad_o)
  );

  l1i_cache u_cache (
    .clk           (clk),
    .rst           (rst),
    .fetch_pc_i    (fetch_pc),
    .flush_all_i   (flush_all),
    .hit_o         (hit),
    .hit_inst_o    (hit_inst),
    .refill_idle_o (refill_idle),
    .mem_araddr_o  (mem_araddr_o),
    .mem_arvalid_o (mem_arvalid_o),
    .mem_rdata_i   (mem_rdata_i),
    .mem_rvalid_i  (mem_rvalid_i)
  );

endmodule

/* verilog/l1i_cache.sv */
`timescale 1ns/1ps

module l1i_cache
  import ifu_cfg_pkg::*;
  import rv_isa_pkg::*;
(
  input  logic              clk,
  input  logic              rst,

  // lookup from the pc controller
  input  logic [ADDR_W-1:0] fetch_pc_i,
  input  logic              flush_all_i,
  output logic              hit_o,
  output logic [INST_W-1:0] hit_inst_o,
  output logic              refill_idle_o,

  // memory read port
  output logic [ADDR_W-1:0] mem_araddr_o,
  output logic              mem_arvalid_o,
  input  logic [INST_W-1:0] mem_rdata_i,
  input  logic              mem_rvalid_i
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_RD_EVEN,
    ST_GAP,
    ST_RD_ODD,
    ST_COMMIT
  } refill_state_e;

  refill_state_e state_q;

  // ----------------------------------------
  // storage
  // ----------------------------------------
  logic [INST_W-1:0] data_q [2**SET_LEN][2**LINE_LEN];
  logic [TAG_W-1:0]  tag_q  [2**SET_LEN];
  logic [2**SET_LEN-1:0] valid_q;

  // refill line address, {tag, set}
  logic [TAG_W+SET_LEN-1:0] line_q;
  logic [SET_LEN-1:0]       refill_set;
  logic [TAG_W-1:0]         refill_tag;
  logic [LINE_LEN-1:0]      word_sel;

  // ----------------------------------------
  // lookup
  // ----------------------------------------
  logic [TAG_W-1:0]    pc_tag;
  logic [SET_LEN-1:0]  pc_set;
  logic [LINE_LEN-1:0] pc_word;
  logic                lookup_hit;

  assign pc_tag  = fetch_pc_i[ADDR_W-1 -: TAG_W];
  assign pc_set  = fetch_pc_i[LINE_LEN+2 +: SET_LEN];
  assign pc_word = fetch_pc_i[2 +: LINE_LEN];

  assign lookup_hit = valid_q[pc_set] && (tag_q[pc_set] == pc_tag);

  // no hits reported while the arrays are being written
  assign hit_o         = (state_q == ST_IDLE) && lookup_hit;
  assign hit_inst_o    = data_q[pc_set][pc_word];
  assign refill_idle_o = (state_q == ST_IDLE);

  // ----------------------------------------
  // refill port
  // ----------------------------------------
  assign refill_set = line_q[SET_LEN-1:0];
  assign refill_tag = line_q[SET_LEN +: TAG_W];

  // even word first, odd word second
  assign word_sel = (state_q == ST_RD_ODD) ? LINE_LEN'(1) : '0;

  assign mem_araddr_o  = {line_q, word_sel, 2'b00};
  assign mem_arvalid_o = (state_q == ST_RD_EVEN) || (state_q == ST_RD_ODD);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (!lookup_hit) begin
            state_q <= ST_RD_EVEN;
          end
        end
        ST_RD_EVEN: begin
          if (mem_rvalid_i) begin
            state_q <= ST_GAP;
          end
        end
        ST_GAP: begin
          state_q <= ST_RD_ODD;
        end
        ST_RD_ODD: begin
          if (mem_rvalid_i) begin
            state_q <= ST_COMMIT;
          end
        end
        ST_COMMIT: begin
          state_q <= ST_IDLE;
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // missing line is captured on the last idle cycle
  always_ff @(posedge clk) begin
    if (state_q == ST_IDLE) begin
      line_q <= fetch_pc_i[ADDR_W-1 -: TAG_W+SET_LEN];
    end
  end

  always_ff @(posedge clk) begin
    if (mem_arvalid_o && mem_rvalid_i) begin
      data_q[refill_set][word_sel] <= mem_rdata_i;
    end
    if (state_q == ST_COMMIT) begin
      tag_q[refill_set] <= refill_tag;
    end
  end

  // ----------------------------------------
  // valid bits and fence.i
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (flush_all_i) begin
      valid_q <= '0;
    end else if (state_q == ST_COMMIT) begin
      valid_q[refill_set] <= 1'b1;
    end
  end

endmodule

/* verilog/rv_isa_pkg.sv */
package rv_isa_pkg;

  // ----------------------------------------
  // instruction word
  // ----------------------------------------
  localparam int INST_W = 32;

  // ----------------------------------------
  // major opcodes, inst[6:0]
  // ----------------------------------------
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  // ecall, ebreak, csr access and mret all stall fetch
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;

  // full fence.i word, funct3 = 001 under MISC-MEM
  localparam logic [INST_W-1:0] INST_FENCE_I = 32'h0000_100f;

endpackage
